// ==== source/wb_pkg.sv ====
package wb_pkg;

  // ##############################
  // Bus geometry
  // ##############################

  localparam int wb_addr_w = 8;  // Byte address, 64 words of 4 bytes
  localparam int wb_data_w = 32;

  // ##############################
  // Wishbone classic signals
  // ##############################

  // Driven by the master, held stable until ack
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [wb_addr_w-1:0] adr;
    logic [wb_data_w-1:0] dat;
  } wb_req_t;

  // Driven by the slave. Writes only, so no read data travels back
  typedef struct packed {
    logic ack;
  } wb_rsp_t;

endpackage

// ==== source/loader_pkg.sv ====
package loader_pkg;

  localparam int clks_per_bit = 16;  // Short bit time keeps simulation fast
  localparam int baud_cnt_w   = $clog2(clks_per_bit);
  localparam int pad_nops     = 6;
  localparam int pad_cnt_w    = $clog2(pad_nops);
  localparam int mem_words    = 64;

  localparam logic [31:0] instr_nop  = 32'h0000_0013;  // addi x0, x0, 0
  localparam logic [31:0] instr_halt = 32'hFFFF_FFFF;  // Also ends the UART program

  // The special words; halt and term share one encoding
  typedef enum logic [1:0] {
    op_nop,
    op_halt,
    op_term
  } opcode_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  typedef enum logic [2:0] {
    ld_collect,
    ld_write,
    ld_pad,
    ld_halt_write,
    ld_started
  } load_state_t;

  // One instruction as the core sees it
  typedef struct packed {
    logic [wb_pkg::wb_addr_w-1:0] pc;
    logic [31:0]                  instr;
  } fetch_out_t;

  function automatic logic [31:0] op_word(opcode_t op);
    case (op)
      op_halt, op_term: return instr_halt;
      default:          return instr_nop;
    endcase
  endfunction

endpackage

// ==== source/uart_rx.sv ====
module uart_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx_serial,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  loader_pkg::rx_state_t state;

  logic                              rx_meta;
  logic                              rx_sync;
  logic                              rx_prev;
  logic [loader_pkg::baud_cnt_w-1:0] baud_cnt;
  logic [2:0]                        bit_idx;

  // ##############################
  // Line synchronizer
  // ##############################

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;  // Idle line is high
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_serial;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ##############################
  // Frame FSM
  // ##############################

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= loader_pkg::rx_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        loader_pkg::rx_idle: begin
          baud_cnt <= '0;
          // A falling edge, so a frame with a bad stop bit cannot retrigger
          if (rx_prev && !rx_sync) begin
            state <= loader_pkg::rx_start;
          end
        end
        loader_pkg::rx_start: begin
          if (baud_cnt == loader_pkg::baud_cnt_w'(loader_pkg::clks_per_bit / 2 - 1)) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_sync ? loader_pkg::rx_idle : loader_pkg::rx_data;  // Glitch check
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        loader_pkg::rx_data: begin
          if (baud_cnt == loader_pkg::baud_cnt_w'(loader_pkg::clks_per_bit - 1)) begin
            baud_cnt <= '0;
            rx_byte  <= {rx_sync, rx_byte[7:1]};  // LSB arrives first
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= loader_pkg::rx_stop;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        loader_pkg::rx_stop: begin
          if (baud_cnt == loader_pkg::baud_cnt_w'(loader_pkg::clks_per_bit - 1)) begin
            baud_cnt <= '0;
            rx_valid <= rx_sync;  // Framing error drops the byte
            state    <= loader_pkg::rx_idle;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= loader_pkg::rx_idle;
      endcase
    end
  end

endmodule

// ==== source/program_loader.sv ====
module program_loader (
  input  logic            clk,
  input  logic            rst,
  input  logic [7:0]      rx_byte,
  input  logic            rx_valid,
  output wb_pkg::wb_req_t wb_req,
  input  wb_pkg::wb_rsp_t wb_rsp,
  output logic            start
);

  loader_pkg::load_state_t state;

  logic [23:0]                      byte_shift;
  logic [1:0]                       byte_cnt;
  logic [wb_pkg::wb_addr_w-1:0]     addr;
  logic [wb_pkg::wb_addr_w-1:0]     addr_next;
  logic [loader_pkg::pad_cnt_w-1:0] pad_cnt;
  logic [31:0]                      word;

  // The incoming byte lands in bits 7:0, earlier bytes move up
  assign word      = {byte_shift, rx_byte};
  assign addr_next = addr + wb_pkg::wb_addr_w'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= loader_pkg::ld_collect;
      byte_cnt <= '0;
      addr     <= '0;
      pad_cnt  <= '0;
      wb_req   <= '0;
      start    <= 1'b0;
    end else begin
      case (state)

        // ##############################
        // Program words from the UART
        // ##############################

        loader_pkg::ld_collect: begin
          if (rx_valid) begin
            byte_shift <= word[23:0];
            byte_cnt   <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3) begin
              if (word == loader_pkg::op_word(loader_pkg::op_term)) begin
                state <= loader_pkg::ld_pad;  // Terminator is never stored
              end else begin
                wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: word};
                state  <= loader_pkg::ld_write;
              end
            end
          end
        end

        loader_pkg::ld_write: begin
          if (wb_rsp.ack) begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.we  <= 1'b0;
            addr       <= addr_next;
            state      <= loader_pkg::ld_collect;
          end
        end

        // ##############################
        // NOP padding and HALT
        // ##############################

        loader_pkg::ld_pad: begin
          if (!wb_req.cyc) begin
            // First cycle after the terminator, open the burst of pad writes
            wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr,
                        dat: loader_pkg::op_word(loader_pkg::op_nop)};
          end else if (wb_rsp.ack) begin
            addr       <= addr_next;
            wb_req.adr <= addr_next;  // Bus stays busy, next write follows at once
            pad_cnt    <= pad_cnt + 1'b1;
            if (pad_cnt == loader_pkg::pad_cnt_w'(loader_pkg::pad_nops - 1)) begin
              wb_req.dat <= loader_pkg::op_word(loader_pkg::op_halt);
              state      <= loader_pkg::ld_halt_write;
            end
          end
        end

        loader_pkg::ld_halt_write: begin
          if (wb_rsp.ack) begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.we  <= 1'b0;
            start      <= 1'b1;
            state      <= loader_pkg::ld_started;
          end
        end

        // Stays here until reset, so late bytes are ignored
        loader_pkg::ld_started: begin
          start <= 1'b1;
        end

        default: state <= loader_pkg::ld_collect;
      endcase
    end
  end

endmodule

// ==== source/instr_mem.sv ====
module instr_mem (
  input  logic                         clk,
  input  logic                         rst,
  input  wb_pkg::wb_req_t              wb_req,
  output wb_pkg::wb_rsp_t              wb_rsp,
  input  logic [wb_pkg::wb_addr_w-1:0] rd_addr,
  output logic [31:0]                  rd_data
);

  logic [31:0] mem [loader_pkg::mem_words];

  logic wr_hit;

  // A new request is one that has not been acknowledged yet
  assign wr_hit = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

  // ##############################
  // Wishbone write port
  // ##############################

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_rsp <= '0;
    end else begin
      wb_rsp.ack <= wr_hit;  // Single cycle ack
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hit && wb_req.we) begin
      mem[wb_req.adr[wb_pkg::wb_addr_w-1:2]] <= wb_req.dat;  // Byte address to word index
    end
  end

  // ##############################
  // Fetch read port
  // ##############################

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr[wb_pkg::wb_addr_w-1:2]];
  end

endmodule

// ==== source/instr_fetch.sv ====
module instr_fetch (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start,
  output logic [wb_pkg::wb_addr_w-1:0] rd_addr,
  input  logic [31:0]                  rd_data,
  output loader_pkg::fetch_out_t       fetch,
  output logic                         instr_valid,
  input  logic                         instr_ready,
  output logic                         halted
);

  logic active;
  logic pend;  // Memory output is the next word to capture
  logic xfer;

  assign xfer = instr_valid && instr_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      active      <= 1'b0;
      pend        <= 1'b0;
      instr_valid <= 1'b0;
      halted      <= 1'b0;
      rd_addr     <= '0;
    end else begin
      if (start && !active) begin
        active <= 1'b1;
        pend   <= 1'b1;  // Address 0 has been on the read port since reset
      end

      if (pend) begin
        fetch       <= '{pc: rd_addr, instr: rd_data};
        instr_valid <= 1'b1;
        pend        <= 1'b0;
        // Prefetch address, the word is ready by the time this one is taken
        rd_addr     <= rd_addr + wb_pkg::wb_addr_w'(4);
      end

      if (xfer) begin
        instr_valid <= 1'b0;
        if (fetch.instr == loader_pkg::op_word(loader_pkg::op_halt)) begin
          halted <= 1'b1;  // Nothing is fetched after HALT
        end else begin
          pend <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/boot_top.sv ====
module boot_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rx_serial,
  output loader_pkg::fetch_out_t fetch,
  output logic                   instr_valid,
  input  logic                   instr_ready,
  output logic                   start,
  output logic                   halted
);

  logic [7:0]                   rx_byte;
  logic                         rx_valid;
  wb_pkg::wb_req_t              wb_req;
  wb_pkg::wb_rsp_t              wb_rsp;
  logic [wb_pkg::wb_addr_w-1:0] rd_addr;
  logic [31:0]                  rd_data;

  // ##############################
  // Producer
  // ##############################

  uart_rx u_uart_rx (
    .clk      (clk),
    .rst      (rst),
    .rx_serial(rx_serial),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  program_loader u_program_loader (
    .clk     (clk),
    .rst     (rst),
    .rx_byte (rx_byte),
    .rx_valid(rx_valid),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .start   (start)
  );

  // Buffer between loader and core
  instr_mem u_instr_mem (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  instr_fetch u_instr_fetch (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .fetch      (fetch),
    .instr_valid(instr_valid),
    .instr_ready(instr_ready),
    .halted     (halted)
  );

endmodule

// ==== tb/boot_sva.sv ====
module boot_sva #(
  parameter int width = 32
) (
  input logic             clk,
  input logic             rst,
  input logic             valid,
  input logic             ready,
  input logic [width-1:0] payload
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // ##############################
  // Handshake rules
  // ##############################

  // An offer stays up until the other side takes it
  held_until_taken: assert property (@(posedge clk) disable iff (rst)
    valid && !ready |=> valid)
    else begin
      $error("Offer withdrawn before it was taken");
      fail_count++;
    end

  payload_stable: assert property (@(posedge clk) disable iff (rst)
    valid && !ready |=> $stable(payload))
    else begin
      $error("Payload changed while waiting to be taken");
      fail_count++;
    end

  idle_after_reset: assert property (@(posedge clk) rst |=> !valid)
    else begin
      $error("Offer raised straight out of reset");
      fail_count++;
    end

endmodule

// ==== tb/boot_checker.sv ====
module boot_checker #(
  parameter int stream_len = 17
) (
  input  logic                   clk,
  input  logic                   rst,
  input  loader_pkg::fetch_out_t fetch,
  input  logic                   instr_valid,
  input  logic                   instr_ready,
  input  logic                   start,
  input  logic                   halted,
  input  logic                   loading,
  input  loader_pkg::fetch_out_t expected [stream_len],
  output int                     err_count,
  output int                     xfer_count
);

  timeunit 1ns;
  timeprecision 1ps;

  logic seen_valid;
  logic halt_done;  // The HALT word has been taken

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    err_count++;
  endtask

  task automatic report_problem(input string what);
    $display("At %0t: %s", $time, what);
    err_count++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      err_count  = 0;
      xfer_count = 0;
      seen_valid <= 1'b0;
      halt_done  <= 1'b0;
    end else begin
      if (loading && start) begin
        report_mismatch("start", 32'(start), 32'd0);
      end
      if ((seen_valid || instr_valid) && !start) begin
        report_mismatch("start", 32'(start), 32'd1);
      end
      if (halted != halt_done) begin
        report_mismatch("halted", 32'(halted), 32'(halt_done));
      end
      if (halt_done && instr_valid) begin
        report_problem("instr_valid rose again after the HALT word was taken");
      end
      if (instr_valid) begin
        seen_valid <= 1'b1;
      end

      // ##############################
      // Compare each accepted word
      // ##############################

      if (instr_valid && instr_ready) begin
        if (xfer_count >= stream_len) begin
          report_problem("More words were delivered than the expected stream holds");
        end else begin
          if (fetch.pc != expected[xfer_count].pc) begin
            report_mismatch("fetch.pc", 32'(fetch.pc), 32'(expected[xfer_count].pc));
          end
          if (fetch.instr != expected[xfer_count].instr) begin
            report_mismatch("fetch.instr", fetch.instr, expected[xfer_count].instr);
          end
          if (xfer_count == stream_len - 1) begin
            halt_done <= 1'b1;
          end
        end
        xfer_count++;
      end
    end
  end

endmodule

// ==== tb/tb_boot.sv ====
module tb_boot;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int prog_words     = 10;
  localparam int stream_len     = prog_words + loader_pkg::pad_nops + 1;
  localparam int total_bytes    = prog_words * 4 + 1 + 4;  // Program, bad frame, terminator
  localparam int timeout_cycles = 2 * (total_bytes * 10 * loader_pkg::clks_per_bit + 200);

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   rx_serial;
  logic                   instr_ready;
  logic                   instr_valid;
  logic                   start;
  logic                   halted;
  logic                   loading;  // High until the last terminator byte goes out
  loader_pkg::fetch_out_t fetch;

  logic [31:0]            prog [prog_words];
  loader_pkg::fetch_out_t expected [stream_len];
  int                     err_count;
  int                     xfer_count;
  int                     sva_fails;
  int                     cycle_cnt = 0;

  always #5 clk = ~clk;

  boot_top u_boot_top (
    .clk        (clk),
    .rst        (rst),
    .rx_serial  (rx_serial),
    .fetch      (fetch),
    .instr_valid(instr_valid),
    .instr_ready(instr_ready),
    .start      (start),
    .halted     (halted)
  );

  boot_checker #(.stream_len(stream_len)) u_boot_checker (
    .clk        (clk),
    .rst        (rst),
    .fetch      (fetch),
    .instr_valid(instr_valid),
    .instr_ready(instr_ready),
    .start      (start),
    .halted     (halted),
    .loading    (loading),
    .expected   (expected),
    .err_count  (err_count),
    .xfer_count (xfer_count)
  );

  bind program_loader boot_sva #(.width($bits(wb_pkg::wb_req_t))) u_wb_sva (
    .clk(clk), .rst(rst), .valid(wb_req.cyc && wb_req.stb), .ready(wb_rsp.ack),
    .payload(wb_req)
  );

  bind instr_fetch boot_sva #(.width($bits(loader_pkg::fetch_out_t))) u_fetch_sva (
    .clk(clk), .rst(rst), .valid(instr_valid), .ready(instr_ready), .payload(fetch)
  );

  // Program words, then the NOP padding, then HALT, each at 4 times its index
  function automatic loader_pkg::fetch_out_t ref_item(input int idx);
    loader_pkg::fetch_out_t item;
    item.pc = wb_pkg::wb_addr_w'(4 * idx);
    if (idx < prog_words) begin
      item.instr = prog[idx];
    end else if (idx < prog_words + loader_pkg::pad_nops) begin
      item.instr = loader_pkg::instr_nop;
    end else begin
      item.instr = loader_pkg::instr_halt;
    end
    return item;
  endfunction

  // 8N1 frame, LSB first
  task automatic send_byte(input logic [7:0] data, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx_serial <= frame[i];
      repeat (loader_pkg::clks_per_bit) @(posedge clk);
    end
  endtask

  task automatic send_word(input logic [31:0] word);
    for (int b = 3; b >= 0; b--) begin
      send_byte(word[8*b +: 8], 1'b1);  // Most significant byte first
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      instr_ready <= 1'b0;
    end else begin
      instr_ready <= ($urandom % 100) < 60;
    end
  end

  // ##############################
  // Stimulus and result
  // ##############################

  initial begin
    logic [31:0] word;
    void'($urandom(96078));
    rst         = 1'b1;
    rx_serial   = 1'b1;
    instr_ready = 1'b0;
    loading     = 1'b1;
    for (int i = 0; i < prog_words; i++) begin
      do word = $urandom; while (word == loader_pkg::instr_halt);
      prog[i] = word;
    end
    for (int i = 0; i < stream_len; i++) begin
      expected[i] = ref_item(i);
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);
    for (int i = 0; i < prog_words; i++) begin
      if (i == 3) begin
        send_byte(8'hA5, 1'b0);  // Broken stop bit, must be dropped
        rx_serial <= 1'b1;
        repeat (loader_pkg::clks_per_bit) @(posedge clk);
      end
      send_word(prog[i]);
    end
    for (int b = 0; b < 3; b++) begin
      send_byte(8'hFF, 1'b1);
    end
    loading <= 1'b0;
    send_byte(8'hFF, 1'b1);
    while (!halted) @(posedge clk);
    repeat (20) @(posedge clk);  // Watch for a stray instr_valid
    sva_fails = u_boot_top.u_program_loader.u_wb_sva.fail_count +
                u_boot_top.u_instr_fetch.u_fetch_sva.fail_count;
    if (xfer_count != stream_len) begin
      $display("Received %0d words, expected %0d", xfer_count, stream_len);
    end
    $display("Errors: %0d compare, %0d assertion; words %0d of %0d",
             err_count, sva_fails, xfer_count, stream_len);
    if (err_count == 0 && sva_fails == 0 && xfer_count == stream_len) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the fetch unit never halted", cycle_cnt);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== tb.f ====
source/wb_pkg.sv
source/loader_pkg.sv
source/uart_rx.sv
source/program_loader.sv
source/instr_mem.sv
source/instr_fetch.sv
source/boot_top.sv
tb/boot_sva.sv
tb/boot_checker.sv
tb/tb_boot.sv

// ==== Bender.yml ====
package:
  name: boot_loader

sources:
  - source/wb_pkg.sv
  - source/loader_pkg.sv
  - source/uart_rx.sv
  - source/program_loader.sv
  - source/instr_mem.sv
  - source/instr_fetch.sv
  - source/boot_top.sv
  - target: test
    files:
      - tb/boot_sva.sv
      - tb/boot_checker.sv
      - tb/tb_boot.sv
